/* fm_regs_pkg.sv */
// FM register map definitions
package fm_regs_pkg;

    localparam int NUM_CH = 6;

    // Timer registers
    localparam logic [7:0] REG_TIMER_A_HI = 8'h24;
    localparam logic [7:0] REG_TIMER_A_LO = 8'h25;
    localparam logic [7:0] REG_TIMER_B    = 8'h26;
    localparam logic [7:0] REG_TIMER_CTL  = 8'h27;

    // Prescaler commands ignore the data byte
    localparam logic [7:0] REG_CLK_N6 = 8'h2D;
    localparam logic [7:0] REG_CLK_N3 = 8'h2E;
    localparam logic [7:0] REG_CLK_N2 = 8'h2F;

    // Channel group bases, offset in the low two bits
    localparam logic [7:0] REG_FNUM_LO = 8'hA0;
    localparam logic [7:0] REG_FNUM_HI = 8'hA4;
    localparam logic [7:0] REG_FB_ALG  = 8'hB0;
    localparam logic [7:0] REG_PAN     = 8'hB4;

    localparam int BUSY_ENABLES = 32; // Synth enables per data write

    localparam int FNUM_W  = 11;
    localparam int BLOCK_W = 3;
    localparam int FB_W    = 3;
    localparam int ALG_W   = 3;
    localparam int PMS_W   = 3;
    localparam int AMS_W   = 2;
    localparam int RL_W    = 2;

    // cen pulses per synth enable for each div_setting
    localparam int DIV_RATIO_11 = 6;
    localparam int DIV_RATIO_10 = 3;
    localparam int DIV_RATIO_01 = 3;
    localparam int DIV_RATIO_00 = 2;

    // One data byte decoded two ways
    typedef union packed {
        struct packed {
            logic [1:0]       pad;
            logic [FB_W-1:0]  fb;
            logic [ALG_W-1:0] alg;
        } fb_alg;
        struct packed {
            logic [RL_W-1:0]  rl;
            logic [AMS_W-1:0] ams;
            logic             pad;
            logic [PMS_W-1:0] pms;
        } pan_view;
    } chan_byte_u;

    typedef enum logic [1:0] {
        FIELD_NONE   = 2'd0,
        FIELD_FREQ   = 2'd1,
        FIELD_FB_ALG = 2'd2,
        FIELD_PAN    = 2'd3
    } chan_field_e;

endpackage

/* fm_clk_div.sv */
// Synth clock prescaler
module fm_clk_div (
    input  logic       clk,
    input  logic       rst,
    input  logic       cen,
    input  logic [1:0] div_setting,
    output logic       clk_en
);

    logic [2:0] cnt;
    logic [2:0] ratio;
    logic [1:0] last_setting; // Detects a new setting

    always_comb begin
        case (div_setting)
            2'b11:   ratio = 3'(fm_regs_pkg::DIV_RATIO_11);
            2'b10:   ratio = 3'(fm_regs_pkg::DIV_RATIO_10);
            2'b01:   ratio = 3'(fm_regs_pkg::DIV_RATIO_01);
            default: ratio = 3'(fm_regs_pkg::DIV_RATIO_00);
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            cnt          <= 3'd0;
            clk_en       <= 1'b0;
            last_setting <= 2'b11;
        end else begin
            clk_en <= 1'b0;
            if (div_setting != last_setting) begin
                // Restart the count on a new ratio
                cnt          <= 3'd0;
                last_setting <= div_setting;
            end else if (cen) begin
                if (cnt == ratio - 3'd1) begin
                    cnt    <= 3'd0;
                    clk_en <= 1'b1;
                end else begin
                    cnt <= cnt + 3'd1;
                end
            end
        end
    end

    // Enable is a single cycle pulse for any real division
    a_clk_en_pulse: assert property (
        @(posedge clk) disable iff (rst)
        (clk_en && ratio > 3'd1) |=> !clk_en
    );

endmodule

/* fm_bus_decode.sv */
// Host bus register decoder
module fm_bus_decode (
    input  logic                      clk,
    input  logic                      rst,
    input  logic [7:0]                din,
    input  logic                      write,
    input  logic [1:0]                addr,
    input  logic                      clk_en,
    output logic                      busy,
    output logic [1:0]                div_setting,
    output logic [9:0]                value_a,
    output logic [7:0]                value_b,
    output logic                      load_a,
    output logic                      load_b,
    output fm_regs_pkg::chan_field_e  wr_field,
    output logic [2:0]                wr_ch,
    output fm_regs_pkg::chan_byte_u   wr_byte,
    output logic [13:0]               wr_freq
);

    logic [7:0] sel_reg;    // Selected register
    logic       part;       // Channels 3 to 5 when set
    logic [5:0] fnum_latch; // Block and fnum[10:8] shared by all channels
    logic       old_write;
    logic [4:0] busy_cnt;
    logic       data_wr;
    logic       data_rise;
    logic [7:0] grp;        // Channel group base of sel_reg
    logic       ch_slot_ok; // Offset 3 has no channel

    assign data_wr    = write && addr[0];
    assign data_rise  = data_wr && !old_write;
    assign grp        = {sel_reg[7:2], 2'b00};
    assign ch_slot_ok = sel_reg[1:0] != 2'b11;

    always_ff @(posedge clk) begin
        if (rst) begin
            sel_reg     <= 8'h00;
            part        <= 1'b0;
            div_setting <= 2'b11;
            value_a     <= 10'd0;
            value_b     <= 8'd0;
            load_a      <= 1'b0;
            load_b      <= 1'b0;
            fnum_latch  <= 6'd0;
            wr_field    <= fm_regs_pkg::FIELD_NONE;
        end else begin
            wr_field <= fm_regs_pkg::FIELD_NONE; // One cycle strobe
            if (write && !addr[0]) begin
                sel_reg <= din;
                part    <= addr[1];
            end else if (data_wr) begin
                case (sel_reg)
                    fm_regs_pkg::REG_TIMER_A_HI: value_a[9:2] <= din;
                    fm_regs_pkg::REG_TIMER_A_LO: value_a[1:0] <= din[1:0];
                    fm_regs_pkg::REG_TIMER_B:    value_b <= din;
                    fm_regs_pkg::REG_TIMER_CTL:  {load_b, load_a} <= din[1:0];
                    fm_regs_pkg::REG_CLK_N6:     div_setting[1] <= 1'b1;
                    fm_regs_pkg::REG_CLK_N3:     div_setting[0] <= 1'b1;
                    fm_regs_pkg::REG_CLK_N2:     div_setting <= 2'b00;
                    default: ;
                endcase
                if (ch_slot_ok) begin
                    case (grp)
                        fm_regs_pkg::REG_FNUM_HI: fnum_latch <= din[5:0];
                        fm_regs_pkg::REG_FNUM_LO: wr_field <= fm_regs_pkg::FIELD_FREQ;
                        fm_regs_pkg::REG_FB_ALG:  wr_field <= fm_regs_pkg::FIELD_FB_ALG;
                        fm_regs_pkg::REG_PAN:     wr_field <= fm_regs_pkg::FIELD_PAN;
                        default: ;
                    endcase
                end
            end
        end
    end

    // Write payload qualified by wr_field
    always_ff @(posedge clk) begin
        if (data_wr) begin
            wr_ch   <= {1'b0, sel_reg[1:0]} + (part ? 3'd3 : 3'd0);
            wr_byte <= din;
            wr_freq <= {fnum_latch, din}; // Latch joined with low byte
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            old_write <= 1'b0;
            busy      <= 1'b0;
            busy_cnt  <= 5'd0;
        end else begin
            old_write <= data_wr;
            if (data_rise) begin
                busy     <= 1'b1;
                busy_cnt <= 5'd0;
            end else if (clk_en && busy) begin
                if (busy_cnt == 5'(fm_regs_pkg::BUSY_ENABLES - 1)) begin
                    busy <= 1'b0;
                end
                busy_cnt <= busy_cnt + 5'd1;
            end
        end
    end

    // Slots only decode channels that exist
    a_wr_ch_range: assert property (
        @(posedge clk) disable iff (rst)
        (wr_field != fm_regs_pkg::FIELD_NONE) |-> (wr_ch < 3'(fm_regs_pkg::NUM_CH))
    );

endmodule

/* fm_chan_regs.sv */
// Per-channel register slot
module fm_chan_regs #(
    parameter logic [2:0] CH_IDX = 3'd0
) (
    input  logic                                clk,
    input  logic                                rst,
    input  fm_regs_pkg::chan_field_e            wr_field,
    input  logic [2:0]                          wr_ch,
    input  fm_regs_pkg::chan_byte_u             wr_byte,
    input  logic [13:0]                         wr_freq,
    output logic [fm_regs_pkg::FNUM_W-1:0]      fnum,
    output logic [fm_regs_pkg::BLOCK_W-1:0]     block,
    output logic [fm_regs_pkg::FB_W-1:0]        fb,
    output logic [fm_regs_pkg::ALG_W-1:0]       alg,
    output logic [fm_regs_pkg::RL_W-1:0]        rl,
    output logic [fm_regs_pkg::AMS_W-1:0]       ams,
    output logic [fm_regs_pkg::PMS_W-1:0]       pms
);

    logic hit;

    assign hit = wr_ch == CH_IDX; // This slot is addressed

    always_ff @(posedge clk) begin
        if (rst) begin
            fnum  <= '0;
            block <= '0;
            fb    <= '0;
            alg   <= '0;
            rl    <= '0;
            ams   <= '0;
            pms   <= '0;
        end else if (hit) begin
            case (wr_field)
                fm_regs_pkg::FIELD_FREQ: begin
                    {block, fnum} <= wr_freq;
                end
                fm_regs_pkg::FIELD_FB_ALG: begin
                    fb  <= wr_byte.fb_alg.fb;
                    alg <= wr_byte.fb_alg.alg;
                end
                fm_regs_pkg::FIELD_PAN: begin
                    // Output enables sit in the top bits
                    rl  <= wr_byte.pan_view.rl;
                    ams <= wr_byte.pan_view.ams;
                    pms <= wr_byte.pan_view.pms;
                end
                default: ;
            endcase
        end
    end

endmodule

/* fm_chan_scan.sv */
// Channel parameter scanner
module fm_chan_scan (
    input  logic                                clk,
    input  logic                                rst,
    input  logic                                clk_en,
    input  logic [fm_regs_pkg::FNUM_W-1:0]      fnum  [fm_regs_pkg::NUM_CH],
    input  logic [fm_regs_pkg::BLOCK_W-1:0]     block [fm_regs_pkg::NUM_CH],
    input  logic [fm_regs_pkg::FB_W-1:0]        fb    [fm_regs_pkg::NUM_CH],
    input  logic [fm_regs_pkg::ALG_W-1:0]       alg   [fm_regs_pkg::NUM_CH],
    input  logic [fm_regs_pkg::RL_W-1:0]        rl    [fm_regs_pkg::NUM_CH],
    input  logic [fm_regs_pkg::AMS_W-1:0]       ams   [fm_regs_pkg::NUM_CH],
    input  logic [fm_regs_pkg::PMS_W-1:0]       pms   [fm_regs_pkg::NUM_CH],
    output logic [2:0]                          cur_ch,
    output logic [fm_regs_pkg::FNUM_W-1:0]      cur_fnum,
    output logic [fm_regs_pkg::BLOCK_W-1:0]     cur_block,
    output logic [fm_regs_pkg::FB_W-1:0]        cur_fb,
    output logic [fm_regs_pkg::ALG_W-1:0]       cur_alg,
    output logic [fm_regs_pkg::RL_W-1:0]        cur_rl,
    output logic [fm_regs_pkg::AMS_W-1:0]       cur_ams,
    output logic [fm_regs_pkg::PMS_W-1:0]       cur_pms
);

    logic [2:0] next_ch;

    // Wrap after the last channel
    assign next_ch = (cur_ch == 3'(fm_regs_pkg::NUM_CH - 1)) ? 3'd0 : cur_ch + 3'd1;

    always_ff @(posedge clk) begin
        if (rst) begin
            cur_ch    <= 3'd0;
            cur_fnum  <= '0;
            cur_block <= '0;
            cur_fb    <= '0;
            cur_alg   <= '0;
            cur_rl    <= '0;
            cur_ams   <= '0;
            cur_pms   <= '0;
        end else if (clk_en) begin
            // Fields follow the channel they are loaded with
            cur_ch    <= next_ch;
            cur_fnum  <= fnum[next_ch];
            cur_block <= block[next_ch];
            cur_fb    <= fb[next_ch];
            cur_alg   <= alg[next_ch];
            cur_rl    <= rl[next_ch];
            cur_ams   <= ams[next_ch];
            cur_pms   <= pms[next_ch];
        end
    end

    a_cur_ch_range: assert property (
        @(posedge clk) disable iff (rst)
        clk_en |=> (cur_ch < 3'(fm_regs_pkg::NUM_CH))
    );

endmodule

/* fm_mmr.sv */
// FM register front end top level
module fm_mmr (
    input  logic                                clk,
    input  logic                                rst,
    input  logic                                cen,
    input  logic [7:0]                          din,
    input  logic                                write,
    input  logic [1:0]                          addr,
    output logic                                clk_en,
    output logic                                busy,
    output logic [9:0]                          value_a,
    output logic [7:0]                          value_b,
    output logic                                load_a,
    output logic                                load_b,
    output logic [2:0]                          cur_ch,
    output logic [fm_regs_pkg::FNUM_W-1:0]      cur_fnum,
    output logic [fm_regs_pkg::BLOCK_W-1:0]     cur_block,
    output logic [fm_regs_pkg::FB_W-1:0]        cur_fb,
    output logic [fm_regs_pkg::ALG_W-1:0]       cur_alg,
    output logic [fm_regs_pkg::RL_W-1:0]        cur_rl,
    output logic [fm_regs_pkg::AMS_W-1:0]       cur_ams,
    output logic [fm_regs_pkg::PMS_W-1:0]       cur_pms
);

    logic [1:0]                 div_setting;
    fm_regs_pkg::chan_field_e   wr_field;
    logic [2:0]                 wr_ch;
    fm_regs_pkg::chan_byte_u    wr_byte;
    logic [13:0]                wr_freq;

    // Stored fields of every slot
    logic [fm_regs_pkg::FNUM_W-1:0]  ch_fnum  [fm_regs_pkg::NUM_CH];
    logic [fm_regs_pkg::BLOCK_W-1:0] ch_block [fm_regs_pkg::NUM_CH];
    logic [fm_regs_pkg::FB_W-1:0]    ch_fb    [fm_regs_pkg::NUM_CH];
    logic [fm_regs_pkg::ALG_W-1:0]   ch_alg   [fm_regs_pkg::NUM_CH];
    logic [fm_regs_pkg::RL_W-1:0]    ch_rl    [fm_regs_pkg::NUM_CH];
    logic [fm_regs_pkg::AMS_W-1:0]   ch_ams   [fm_regs_pkg::NUM_CH];
    logic [fm_regs_pkg::PMS_W-1:0]   ch_pms   [fm_regs_pkg::NUM_CH];

    fm_clk_div clk_div_i (
        .clk         (clk),
        .rst         (rst),
        .cen         (cen),
        .div_setting (div_setting),
        .clk_en      (clk_en)
    );

    fm_bus_decode bus_decode_i (
        .clk         (clk),
        .rst         (rst),
        .din         (din),
        .write       (write),
        .addr        (addr),
        .clk_en      (clk_en),
        .busy        (busy),
        .div_setting (div_setting),
        .value_a     (value_a),
        .value_b     (value_b),
        .load_a      (load_a),
        .load_b      (load_b),
        .wr_field    (wr_field),
        .wr_ch       (wr_ch),
        .wr_byte     (wr_byte),
        .wr_freq     (wr_freq)
    );

    for (genvar i = 0; i < fm_regs_pkg::NUM_CH; i++) begin : g_slot
        fm_chan_regs #(
            .CH_IDX (3'(i))
        ) chan_regs_i (
            .clk      (clk),
            .rst      (rst),
            .wr_field (wr_field),
            .wr_ch    (wr_ch),
            .wr_byte  (wr_byte),
            .wr_freq  (wr_freq),
            .fnum     (ch_fnum[i]),
            .block    (ch_block[i]),
            .fb       (ch_fb[i]),
            .alg      (ch_alg[i]),
            .rl       (ch_rl[i]),
            .ams      (ch_ams[i]),
            .pms      (ch_pms[i])
        );
    end

    fm_chan_scan chan_scan_i (
        .clk       (clk),
        .rst       (rst),
        .clk_en    (clk_en),
        .fnum      (ch_fnum),
        .block     (ch_block),
        .fb        (ch_fb),
        .alg       (ch_alg),
        .rl        (ch_rl),
        .ams       (ch_ams),
        .pms       (ch_pms),
        .cur_ch    (cur_ch),
        .cur_fnum  (cur_fnum),
        .cur_block (cur_block),
        .cur_fb    (cur_fb),
        .cur_alg   (cur_alg),
        .cur_rl    (cur_rl),
        .cur_ams   (cur_ams),
        .cur_pms   (cur_pms)
    );

endmodule

/* fm_mmr_tb.sv */
// FM register front end testbench
module fm_mmr_tb;
    timeunit 1ns;
    timeprecision 1ps;

    typedef struct packed {
        logic       part;
        logic [7:0] rg;
        logic [7:0] data;
        logic       rnd;  // Data byte from the LCG
        logic       meas; // Count the enables of the busy window
    } step_t;

    localparam int TABLE_LEN = 24;
    localparam int LIMIT = TABLE_LEN * (fm_regs_pkg::BUSY_ENABLES * 6 + 8) + 200;

    localparam step_t STEPS [TABLE_LEN] = '{
        '{1'b0, fm_regs_pkg::REG_CLK_N2, 8'h00, 1'b0, 1'b1},
        '{1'b0, 8'h24, 8'hA5, 1'b0, 1'b1},
        '{1'b0, 8'h25, 8'h03, 1'b0, 1'b0},
        '{1'b0, 8'h26, 8'hC3, 1'b0, 1'b0},
        '{1'b0, 8'h27, 8'h03, 1'b0, 1'b1},
        '{1'b0, 8'hA4, 8'h2D, 1'b0, 1'b0},
        '{1'b0, 8'hA0, 8'h00, 1'b1, 1'b1},
        '{1'b1, 8'hA5, 8'h17, 1'b0, 1'b0},
        '{1'b1, 8'hA1, 8'h00, 1'b1, 1'b0},
        '{1'b0, 8'hA6, 8'h3A, 1'b0, 1'b0},
        '{1'b1, 8'hA2, 8'h00, 1'b1, 1'b1}, // Shared latch lands on channel 5
        '{1'b0, 8'hA3, 8'h00, 1'b1, 1'b0},
        '{1'b1, 8'hA7, 8'h3F, 1'b0, 1'b0}, // Offset 3 leaves the latch alone
        '{1'b0, 8'hA1, 8'h00, 1'b1, 1'b0},
        '{1'b0, fm_regs_pkg::REG_CLK_N3, 8'h00, 1'b0, 1'b1},
        '{1'b0, 8'hB0, 8'h00, 1'b1, 1'b0},
        '{1'b1, 8'hB2, 8'h00, 1'b1, 1'b1},
        '{1'b0, 8'hB4, 8'h00, 1'b1, 1'b0},
        '{1'b1, 8'hB5, 8'h00, 1'b1, 1'b0},
        '{1'b1, 8'hB3, 8'h00, 1'b1, 1'b0},
        '{1'b0, fm_regs_pkg::REG_CLK_N6, 8'h00, 1'b0, 1'b1},
        '{1'b0, 8'hB6, 8'h00, 1'b1, 1'b0},
        '{1'b1, 8'hB1, 8'h00, 1'b1, 1'b1},
        '{1'b0, 8'h27, 8'h00, 1'b1, 1'b0}
    };

    logic clk, rst, cen, write, clk_en, busy, load_a, load_b;
    logic [7:0] din;
    logic [1:0] addr;
    logic [9:0] value_a;
    logic [7:0] value_b;
    logic [2:0] cur_ch;
    logic [fm_regs_pkg::FNUM_W-1:0]  cur_fnum;
    logic [fm_regs_pkg::BLOCK_W-1:0] cur_block;
    logic [fm_regs_pkg::FB_W-1:0]    cur_fb;
    logic [fm_regs_pkg::ALG_W-1:0]   cur_alg;
    logic [fm_regs_pkg::RL_W-1:0]    cur_rl;
    logic [fm_regs_pkg::AMS_W-1:0]   cur_ams;
    logic [fm_regs_pkg::PMS_W-1:0]   cur_pms;

    // Reference model state
    logic [fm_regs_pkg::FNUM_W-1:0]  m_fnum  [fm_regs_pkg::NUM_CH];
    logic [fm_regs_pkg::BLOCK_W-1:0] m_block [fm_regs_pkg::NUM_CH];
    logic [fm_regs_pkg::FB_W-1:0]    m_fb    [fm_regs_pkg::NUM_CH];
    logic [fm_regs_pkg::ALG_W-1:0]   m_alg   [fm_regs_pkg::NUM_CH];
    logic [fm_regs_pkg::RL_W-1:0]    m_rl    [fm_regs_pkg::NUM_CH];
    logic [fm_regs_pkg::AMS_W-1:0]   m_ams   [fm_regs_pkg::NUM_CH];
    logic [fm_regs_pkg::PMS_W-1:0]   m_pms   [fm_regs_pkg::NUM_CH];
    logic [5:0]  m_latch = 6'd0;
    logic [9:0]  m_va = 10'd0;
    logic [7:0]  m_vb = 8'd0;
    logic        m_la = 1'b0;
    logic        m_lb = 1'b0;
    logic [1:0]  m_div = 2'b11;
    logic [2:0]  m_scan; // Channel the scanner should show
    logic [31:0] lcg_state = 32'd91012;
    int err_chan = 0, err_timer = 0, err_busy = 0, err_div = 0;
    int cycles = 0;

    fm_mmr fm_mmr_i (.*);

    always #20 clk = ~clk;

    always @(posedge clk) begin
        cycles++;
        if (cycles >= LIMIT) begin
            $display("Timeout: run did not complete within %0d cycles", LIMIT);
            $display("tests failed");
            $finish;
        end
    end

    // One scanner step per synth enable
    always @(posedge clk) begin
        if (rst) begin
            m_scan <= 3'd0;
        end else if (clk_en) begin
            m_scan <= 3'((int'(m_scan) + 1) % fm_regs_pkg::NUM_CH);
        end
    end

    function automatic logic [7:0] next_rand();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state[23:16];
    endfunction

    task automatic report_mismatch(input string msg);
        $display("Fail %0t: %s", $time, msg);
    endtask

    task automatic check_chan(input logic [2:0] ch,
                              input logic [fm_regs_pkg::FNUM_W-1:0] fnum,
                              input logic [fm_regs_pkg::BLOCK_W-1:0] block,
                              input logic [fm_regs_pkg::FB_W-1:0] fb,
                              input logic [fm_regs_pkg::ALG_W-1:0] alg,
                              input logic [fm_regs_pkg::RL_W-1:0] rl,
                              input logic [fm_regs_pkg::AMS_W-1:0] ams,
                              input logic [fm_regs_pkg::PMS_W-1:0] pms);
        string got;
        string want;
        got = $sformatf("%0d %h %0d %0d %0d %0d %0d %0d", cur_ch, cur_fnum, cur_block,
                        cur_fb, cur_alg, cur_rl, cur_ams, cur_pms);
        want = $sformatf("%0d %h %0d %0d %0d %0d %0d %0d", ch, fnum, block,
                         fb, alg, rl, ams, pms);
        if ({cur_ch, cur_fnum, cur_block, cur_fb, cur_alg, cur_rl, cur_ams, cur_pms} !==
            {ch, fnum, block, fb, alg, rl, ams, pms}) begin
            err_chan++;
            report_mismatch({"scanner ch fnum blk fb alg rl ams pms ", got, ", want ", want});
        end
    endtask

    task automatic check_timer(input logic [9:0] va, input logic [7:0] vb,
                               input logic la, input logic lb);
        if ({value_a, value_b, load_a, load_b} !== {va, vb, la, lb}) begin
            err_timer++;
            report_mismatch($sformatf("timers a %h b %h loads %b%b, want %h %h %b%b",
                value_a, value_b, load_b, load_a, va, vb, lb, la));
        end
    endtask

    task automatic check_busy(input logic want, input int len, input int want_len,
                              input string what);
        if (busy !== want || len != want_len) begin
            err_busy++;
            report_mismatch($sformatf("%s: busy %b for %0d enables, want %b for %0d",
                what, busy, len, want, want_len));
        end
    endtask

    task automatic check_ratio();
        int gap;
        int want;
        gap = 0;
        case (m_div)
            2'b11:   want = 6;
            2'b00:   want = 2;
            default: want = 3;
        endcase
        while (!clk_en) @(negedge clk);
        do begin
            @(negedge clk);
            gap++;
        end while (!clk_en);
        if (gap != want) begin
            err_div++;
            report_mismatch($sformatf("clk_en spacing %0d, want %0d", gap, want));
        end
    endtask

    // Address write, then data write, one cycle each
    task automatic write_reg(input logic part, input logic [7:0] rg, input logic [7:0] d);
        write = 1'b1;
        addr = {part, 1'b0};
        din = rg;
        @(posedge clk);
        #2;
        check_busy(1'b0, 0, 0, "address write");
        addr = {part, 1'b1};
        din = d;
        @(posedge clk);
        #2;
        write = 1'b0;
    endtask

    task automatic apply_model(input logic part, input logic [7:0] rg, input logic [7:0] d);
        logic [2:0] ch;
        ch = 3'(rg[1:0] + 3 * part);
        case (rg)
            8'h24: m_va[9:2] = d;
            8'h25: m_va[1:0] = d[1:0];
            8'h26: m_vb = d;
            8'h27: {m_lb, m_la} = d[1:0];
            8'h2D: m_div[1] = 1'b1;
            8'h2E: m_div[0] = 1'b1;
            8'h2F: m_div = 2'b00;
            default: ;
        endcase
        if (rg[1:0] != 2'b11) begin
            case (rg & 8'hFC)
                8'hA4: m_latch = d[5:0];
                8'hA0: {m_block[ch], m_fnum[ch]} = {m_latch, d};
                8'hB0: {m_fb[ch], m_alg[ch]} = d[5:0];
                8'hB4: {m_rl[ch], m_ams[ch], m_pms[ch]} = {d[7:4], d[2:0]};
                default: ;
            endcase
        end
    endtask

    // Also checks the scanner on each enable once the new value has landed
    task automatic wait_busy(input logic measure);
        int n;
        logic en_prev;
        n = 0;
        @(negedge clk);
        check_busy(1'b1, 0, 0, "data write");
        while (busy) begin
            if (clk_en) n++;
            en_prev = clk_en;
            @(negedge clk);
            if (en_prev && n >= 2) begin
                check_chan(m_scan, m_fnum[m_scan], m_block[m_scan], m_fb[m_scan],
                           m_alg[m_scan], m_rl[m_scan], m_ams[m_scan], m_pms[m_scan]);
            end
        end
        if (measure) check_busy(1'b0, n, fm_regs_pkg::BUSY_ENABLES, "busy window");
    endtask

    initial begin
        logic [7:0] d;
        clk = 1'b0;
        rst = 1'b1;
        cen = 1'b1;
        write = 1'b0;
        addr = 2'b00;
        din = 8'h00;
        foreach (m_fnum[c]) begin
            {m_fnum[c], m_block[c], m_fb[c], m_alg[c]} = '0;
            {m_rl[c], m_ams[c], m_pms[c]} = '0;
        end
        repeat (4) @(posedge clk);
        #2;
        rst = 1'b0;
        check_busy(1'b0, 0, 0, "after reset");
        check_timer(10'd0, 8'd0, 1'b0, 1'b0);
        check_chan(3'd0, '0, '0, '0, '0, '0, '0, '0);
        for (int i = 0; i < TABLE_LEN; i++) begin
            d = STEPS[i].rnd ? next_rand() : STEPS[i].data;
            write_reg(STEPS[i].part, STEPS[i].rg, d);
            apply_model(STEPS[i].part, STEPS[i].rg, d);
            wait_busy(STEPS[i].meas);
            check_timer(m_va, m_vb, m_la, m_lb);
            if (STEPS[i].rg inside {8'h2D, 8'h2E, 8'h2F}) check_ratio();
            @(posedge clk);
            #2;
        end
        $display("Errors: chan %0d, timer %0d, busy %0d, divider %0d",
                 err_chan, err_timer, err_busy, err_div);
        if (err_chan + err_timer + err_busy + err_div == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

/* tb.f */
fm_regs_pkg.sv
fm_clk_div.sv
fm_bus_decode.sv
fm_chan_regs.sv
fm_chan_scan.sv
fm_mmr.sv
fm_mmr_tb.sv

/* Makefile */
TOP = fm_mmr_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f tb.f --top-module fm_mmr
	verilator --lint-only --timing -f tb.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f tb.f --top-module $(TOP) -o $(TOP)
	./obj_dir/$(TOP) | tee sim.log
	grep -qx "all tests passed" sim.log

clean:
	rm -rf obj_dir sim.log
